// ==== rtl/video_stream_pkg.sv ====
package video_stream_pkg;

   typedef enum logic [2:0] {
      dtype_frame_start = 3'd0,
      dtype_row_end     = 3'd1,
      dtype_frame_end   = 3'd2,
      dtype_pixel       = 3'd3
   } stream_dtype_t;

   typedef struct packed {
      logic          dv;
      stream_dtype_t dtype;
      logic [7:0]    data0;   // y
      logic [7:0]    data1;   // u
      logic [7:0]    data2;   // v
      logic [15:0]   meta;
   } stream_beat_t;

   // chroma is shared by the pair, v rides in the high pixel and u in the low one
   typedef struct packed {
      logic [2:0] a;
      logic [6:0] y;
      logic [5:0] v;
   } ovl_px_hi_t;

   typedef struct packed {
      logic [2:0] a;
      logic [6:0] y;
      logic [5:0] u;
   } ovl_px_lo_t;

   typedef struct packed {
      ovl_px_hi_t hi;   // second pixel of the pair
      ovl_px_lo_t lo;   // first pixel
   } ovl_pair_t;

   typedef union packed {
      logic [31:0] raw;
      ovl_pair_t   pair;
   } ovl_word_t;

endpackage

// ==== rtl/ovl_bus_pkg.sv ====
package ovl_bus_pkg;

   localparam int axil_addr_width = 8;
   localparam int axil_data_width = 32;
   localparam int mem_addr_width  = 16;   // widest RAM address a request can carry

   localparam logic [1:0] axil_resp_okay = 2'b00;

   // register map
   localparam logic [7:0] reg_ctrl     = 8'h00;   // bit 0 enable
   localparam logic [7:0] reg_origin   = 8'h04;   // row start high, col start low
   localparam logic [7:0] reg_size     = 8'h08;   // rows high, cols low
   localparam logic [7:0] reg_mem_addr = 8'h0C;   // RAM write pointer
   localparam logic [7:0] reg_mem_data = 8'h10;   // store word, bump pointer

   typedef struct packed {
      logic                       awvalid;
      logic [axil_addr_width-1:0] awaddr;
      logic                       wvalid;
      logic [axil_data_width-1:0] wdata;
      logic                       bready;
      logic                       arvalid;
      logic [axil_addr_width-1:0] araddr;
      logic                       rready;
   } axil_req_t;

   typedef struct packed {
      logic                       awready;
      logic                       wready;
      logic                       bvalid;
      logic [1:0]                 bresp;
      logic                       arready;
      logic                       rvalid;
      logic [axil_data_width-1:0] rdata;
      logic [1:0]                 rresp;
   } axil_rsp_t;

   typedef struct packed {
      logic                        req;
      logic                        we;
      logic [mem_addr_width-1:0]   addr;
      video_stream_pkg::ovl_word_t wdata;
   } mem_req_t;

endpackage

// ==== rtl/ovl_regs.sv ====
`timescale 1ns/1ps

module ovl_regs import ovl_bus_pkg::*; #(
   parameter int DIM_WIDTH      = 11,
   parameter int OVL_ADDR_WIDTH = 10
) (
   input  logic                 clk,
   input  logic                 resetb,
   input  axil_req_t            axil_req,
   output axil_rsp_t            axil_rsp,
   output logic                 enable,
   output logic [DIM_WIDTH-1:0] col_start,
   output logic [DIM_WIDTH-1:0] row_start,
   output logic [DIM_WIDTH-1:0] num_cols,
   output logic [DIM_WIDTH-1:0] num_rows,
   output mem_req_t             mem_req,
   input  logic                 mem_gnt
);

   logic                      wr_ready;   // awready and wready together
   logic                      ar_ready;
   logic                      bvalid;
   logic                      rvalid;
   logic                      mem_pend;   // RAM write waiting for the arbiter
   logic [OVL_ADDR_WIDTH-1:0] wr_ptr;
   logic [31:0]               mem_wdata;
   logic [31:0]               rdata;
   logic                      wr_fire;
   logic                      rd_fire;
   logic [31:0]               rd_word;

   assign wr_fire = axil_req.awvalid && axil_req.wvalid && wr_ready;
   assign rd_fire = axil_req.arvalid && ar_ready;

   always_comb begin
      case (axil_req.araddr)
         reg_ctrl:     rd_word = {31'd0, enable};
         reg_origin:   rd_word = {16'(row_start), 16'(col_start)};
         reg_size:     rd_word = {16'(num_rows), 16'(num_cols)};
         reg_mem_addr: rd_word = 32'(wr_ptr);
         default:      rd_word = '0;   // RAM is write-only from the bus
      endcase
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         wr_ready  <= 1'b0;
         ar_ready  <= 1'b0;
         bvalid    <= 1'b0;
         rvalid    <= 1'b0;
         mem_pend  <= 1'b0;
         wr_ptr    <= '0;
         enable    <= 1'b0;
         col_start <= '0;
         row_start <= '0;
         num_cols  <= '0;
         num_rows  <= '0;
      end else begin
         // one write at a time, nothing new until the response is taken
         wr_ready <= axil_req.awvalid && axil_req.wvalid && !wr_ready && !bvalid && !mem_pend;
         ar_ready <= axil_req.arvalid && !ar_ready && !rvalid;

         if (wr_fire) begin
            case (axil_req.awaddr)
               reg_ctrl: enable <= axil_req.wdata[0];
               reg_origin: begin
                  col_start <= axil_req.wdata[DIM_WIDTH-1:0];
                  row_start <= axil_req.wdata[16 +: DIM_WIDTH];
               end
               reg_size: begin
                  num_cols <= axil_req.wdata[DIM_WIDTH-1:0];
                  num_rows <= axil_req.wdata[16 +: DIM_WIDTH];
               end
               reg_mem_addr: wr_ptr <= axil_req.wdata[OVL_ADDR_WIDTH-1:0];
               default: ;
            endcase
            if (axil_req.awaddr == reg_mem_data)
               mem_pend <= 1'b1;
            else
               bvalid <= 1'b1;
         end

         if (mem_pend && mem_gnt) begin
            mem_pend <= 1'b0;
            wr_ptr   <= wr_ptr + 1'b1;
            bvalid   <= 1'b1;   // response only once the word is in RAM
         end

         if (bvalid && axil_req.bready)
            bvalid <= 1'b0;

         if (rd_fire)
            rvalid <= 1'b1;
         else if (rvalid && axil_req.rready)
            rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_fire)
         mem_wdata <= axil_req.wdata;
      if (rd_fire)
         rdata <= rd_word;
   end

   always_comb begin
      axil_rsp.awready = wr_ready;
      axil_rsp.wready  = wr_ready;
      axil_rsp.bvalid  = bvalid;
      axil_rsp.bresp   = axil_resp_okay;
      axil_rsp.arready = ar_ready;
      axil_rsp.rvalid  = rvalid;
      axil_rsp.rdata   = rdata;
      axil_rsp.rresp   = axil_resp_okay;

      mem_req.req       = mem_pend;
      mem_req.we        = 1'b1;
      mem_req.addr      = mem_addr_width'(wr_ptr);
      mem_req.wdata.raw = mem_wdata;
   end

endmodule

// ==== rtl/ovl_mem_arbiter.sv ====
`timescale 1ns/1ps

module ovl_mem_arbiter import video_stream_pkg::*, ovl_bus_pkg::*; #(
   parameter int OVL_ADDR_WIDTH = 10
) (
   input  logic      clk,
   input  mem_req_t  fetch_req,
   input  mem_req_t  bus_req,
   output logic      bus_gnt,
   output ovl_word_t rdata
);

   logic [31:0]               ram [2**OVL_ADDR_WIDTH];
   mem_req_t                  sel;
   logic [OVL_ADDR_WIDTH-1:0] sel_addr;

   // the fetcher feeds live video, so it always wins and the bus waits
   assign bus_gnt  = bus_req.req && !fetch_req.req;
   assign sel      = fetch_req.req ? fetch_req : bus_req;
   assign sel_addr = sel.addr[OVL_ADDR_WIDTH-1:0];

   // single port, one access per cycle, read or write
   always_ff @(posedge clk) begin
      if (sel.req) begin
         if (sel.we)
            ram[sel_addr] <= sel.wdata.raw;
         else
            rdata.raw <= ram[sel_addr];   // ready the cycle after the grant
      end
   end

endmodule

// ==== rtl/ovl_fetch.sv ====
`timescale 1ns/1ps

module ovl_fetch import video_stream_pkg::*, ovl_bus_pkg::*; #(
   parameter int OVL_ADDR_WIDTH = 10
) (
   input  logic      clk,
   input  logic      resetb,
   output mem_req_t  mem_req,
   input  ovl_word_t rdata,
   input  logic      ovl_adv,
   input  logic      ovl_restart,
   output ovl_word_t ovl_data
);

   logic [OVL_ADDR_WIDTH-1:0] rd_addr;
   ovl_word_t                 cur_word;
   ovl_word_t                 buf_word;
   logic                      cur_vld;
   logic                      buf_vld;
   logic                      rd_pend;   // rdata holds our word this cycle
   ovl_word_t                 nxt_cur;
   ovl_word_t                 nxt_buf;
   logic                      nxt_cur_vld;
   logic                      nxt_buf_vld;
   logic                      issue;

   always_comb begin
      nxt_cur     = cur_word;
      nxt_cur_vld = cur_vld;
      nxt_buf     = buf_word;
      nxt_buf_vld = buf_vld;
      if (ovl_adv) begin   // promote the prefetched word
         nxt_cur     = buf_word;
         nxt_cur_vld = buf_vld;
         nxt_buf_vld = 1'b0;
      end
      if (rd_pend) begin
         if (!nxt_cur_vld) begin
            nxt_cur     = rdata;
            nxt_cur_vld = 1'b1;
         end else begin
            nxt_buf     = rdata;
            nxt_buf_vld = 1'b1;
         end
      end
   end

   // read again as soon as a slot is free for the returning word
   assign issue    = !ovl_restart && !(nxt_cur_vld && nxt_buf_vld);
   assign ovl_data = cur_word;

   always_comb begin
      mem_req.req   = issue;
      mem_req.we    = 1'b0;
      mem_req.addr  = mem_addr_width'(rd_addr);
      mem_req.wdata = '0;
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         rd_addr <= '0;
         cur_vld <= 1'b0;
         buf_vld <= 1'b0;
         rd_pend <= 1'b0;
      end else if (ovl_restart) begin   // drop everything, in-flight read too
         rd_addr <= '0;
         cur_vld <= 1'b0;
         buf_vld <= 1'b0;
         rd_pend <= 1'b0;
      end else begin
         cur_vld <= nxt_cur_vld;
         buf_vld <= nxt_buf_vld;
         rd_pend <= issue;
         if (issue)
            rd_addr <= rd_addr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      cur_word <= nxt_cur;
      buf_word <= nxt_buf;
   end

endmodule

// ==== rtl/overlay_blend.sv ====
`timescale 1ns/1ps

module overlay_blend import video_stream_pkg::*; #(
   parameter int DIM_WIDTH = 11
) (
   input  logic                 clk,
   input  logic                 resetb,
   input  logic                 enable,
   input  logic [DIM_WIDTH-1:0] col_start,
   input  logic [DIM_WIDTH-1:0] row_start,
   input  logic [DIM_WIDTH-1:0] num_cols,
   input  logic [DIM_WIDTH-1:0] num_rows,
   input  ovl_word_t            ovl_data,
   output logic                 ovl_adv,
   output logic                 ovl_restart,
   input  stream_beat_t         beat_in,
   output stream_beat_t         beat_out
);

   logic [DIM_WIDTH-1:0] row_pos;
   logic [DIM_WIDTH-1:0] col_pos;
   logic [DIM_WIDTH-1:0] row_end;
   logic [DIM_WIDTH-1:0] col_end;
   logic                 phase;   // high on the second pixel of a pair
   logic                 in_rect;
   logic                 ovl_en;
   logic                 ovl_sel;
   logic [2:0]           ovl_a;
   logic [7:0]           ovl_y;
   logic [7:0]           ovl_u;
   logic [7:0]           ovl_v;
   stream_beat_t         mixed;

   function automatic logic [7:0] blend_chan(
      input logic [7:0] base,
      input logic [7:0] ovl,
      input logic [2:0] a
   );
      logic [2:0]  b;
      logic [10:0] sum;
      b   = 3'd7 - a;
      sum = 11'(base) * 11'(b) + 11'(ovl) * 11'(a);   // weights add to 7, fits in 11 bits
      if (a == 3'd7)
         return ovl;
      else if (a == 3'd0)
         return base;
      else
         return sum[10:3];
   endfunction

   assign row_end = row_start + num_rows;
   assign col_end = col_start + num_cols;
   assign in_rect = row_pos >= row_start && row_pos < row_end &&
                    col_pos >= col_start && col_pos < col_end;
   assign ovl_en  = enable && beat_in.dv && beat_in.dtype == dtype_pixel && in_rect;
   assign ovl_adv = ovl_en && phase;   // word used up after its high pixel

   always_comb begin
      if (phase) begin
         ovl_a   = ovl_data.pair.hi.a;
         ovl_y   = {ovl_data.pair.hi.y, 1'b0};
         ovl_sel = ovl_data.pair.hi != '0;
      end else begin
         ovl_a   = ovl_data.pair.lo.a;
         ovl_y   = {ovl_data.pair.lo.y, 1'b0};
         ovl_sel = ovl_data.pair.lo != '0;
      end
      ovl_u = {ovl_data.pair.lo.u, 2'b00};
      ovl_v = {ovl_data.pair.hi.v, 2'b00};

      mixed = beat_in;
      if (ovl_en && ovl_sel) begin   // all-zero half means transparent
         mixed.data0 = blend_chan(beat_in.data0, ovl_y, ovl_a);
         mixed.data1 = blend_chan(beat_in.data1, ovl_u, ovl_a);
         mixed.data2 = blend_chan(beat_in.data2, ovl_v, ovl_a);
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         beat_out    <= '0;
         row_pos     <= '0;
         col_pos     <= '0;
         phase       <= 1'b0;
         ovl_restart <= 1'b0;
      end else if (!enable) begin
         beat_out    <= beat_in;
         row_pos     <= '0;
         col_pos     <= '0;
         phase       <= 1'b0;
         ovl_restart <= 1'b0;
      end else begin
         beat_out    <= mixed;
         ovl_restart <= beat_in.dv && beat_in.dtype == dtype_frame_end;
         if (beat_in.dv) begin
            case (beat_in.dtype)
               dtype_frame_start: begin
                  row_pos <= '0;
                  col_pos <= '0;
               end
               dtype_row_end: begin
                  row_pos <= row_pos + 1'b1;
                  col_pos <= '0;
               end
               dtype_pixel: col_pos <= col_pos + 1'b1;
               dtype_frame_end: phase <= 1'b0;   // next frame opens on a low pixel
               default: ;
            endcase
         end
         if (ovl_en)
            phase <= !phase;
      end
   end

endmodule

// ==== rtl/overlay_top.sv ====
`timescale 1ns/1ps

module overlay_top import video_stream_pkg::*, ovl_bus_pkg::*; #(
   parameter int DIM_WIDTH      = 11,
   parameter int OVL_ADDR_WIDTH = 10
) (
   input  logic         clk,
   input  logic         resetb,
   input  axil_req_t    axil_req,
   output axil_rsp_t    axil_rsp,
   input  stream_beat_t beat_in,
   output stream_beat_t beat_out
);

   logic                 enable;
   logic [DIM_WIDTH-1:0] col_start;
   logic [DIM_WIDTH-1:0] row_start;
   logic [DIM_WIDTH-1:0] num_cols;
   logic [DIM_WIDTH-1:0] num_rows;
   mem_req_t             bus_mem_req;
   mem_req_t             fetch_mem_req;
   logic                 bus_gnt;
   ovl_word_t            rdata;
   ovl_word_t            ovl_data;
   logic                 ovl_adv;
   logic                 ovl_restart;

   ovl_regs #(
      .DIM_WIDTH      (DIM_WIDTH),
      .OVL_ADDR_WIDTH (OVL_ADDR_WIDTH)
   ) u_regs (
      .clk       (clk),
      .resetb    (resetb),
      .axil_req  (axil_req),
      .axil_rsp  (axil_rsp),
      .enable    (enable),
      .col_start (col_start),
      .row_start (row_start),
      .num_cols  (num_cols),
      .num_rows  (num_rows),
      .mem_req   (bus_mem_req),
      .mem_gnt   (bus_gnt)
   );

   ovl_mem_arbiter #(
      .OVL_ADDR_WIDTH (OVL_ADDR_WIDTH)
   ) u_arbiter (
      .clk       (clk),
      .fetch_req (fetch_mem_req),
      .bus_req   (bus_mem_req),
      .bus_gnt   (bus_gnt),
      .rdata     (rdata)
   );

   ovl_fetch #(
      .OVL_ADDR_WIDTH (OVL_ADDR_WIDTH)
   ) u_fetch (
      .clk         (clk),
      .resetb      (resetb),
      .mem_req     (fetch_mem_req),
      .rdata       (rdata),
      .ovl_adv     (ovl_adv),
      .ovl_restart (ovl_restart),
      .ovl_data    (ovl_data)
   );

   overlay_blend #(
      .DIM_WIDTH (DIM_WIDTH)
   ) u_blend (
      .clk         (clk),
      .resetb      (resetb),
      .enable      (enable),
      .col_start   (col_start),
      .row_start   (row_start),
      .num_cols    (num_cols),
      .num_rows    (num_rows),
      .ovl_data    (ovl_data),
      .ovl_adv     (ovl_adv),
      .ovl_restart (ovl_restart),
      .beat_in     (beat_in),
      .beat_out    (beat_out)
   );

endmodule

// ==== verification/overlay_checker.sv ====
`timescale 1ns/1ps

module overlay_checker import video_stream_pkg::*, ovl_bus_pkg::*; (
   input  logic         clk,
   input  logic         resetb,
   input  stream_beat_t beat_out,
   input  stream_beat_t exp_beat,
   input  axil_req_t    axil_req,
   input  axil_rsp_t    axil_rsp,
   input  logic [31:0]  exp_rdata,
   output int           beat_errors,
   output int           read_errors,
   output int           bus_errors,
   output int           beats_checked,
   output int           reads_checked
);

   stream_beat_t exp_q;   // what beat_out must hold now, one cycle behind the input

   initial begin
      beat_errors   = 0;
      read_errors   = 0;
      bus_errors    = 0;
      beats_checked = 0;
      reads_checked = 0;
      exp_q         = '0;
   end

   always @(posedge clk) begin
      if (!resetb) begin
         exp_q = '0;
      end else begin
         if (beat_out !== exp_q) begin
            beat_errors++;
            $display("error %0t: beat_out %h, expected %h", $time, beat_out, exp_q);
         end
         if (beat_out.dv)
            beats_checked++;
         exp_q = exp_beat;
         if (axil_rsp.awready !== axil_rsp.wready) begin
            bus_errors++;
            $display("error %0t: awready %b and wready %b differ", $time,
                     axil_rsp.awready, axil_rsp.wready);
         end
         if (axil_rsp.bvalid && axil_rsp.bresp !== 2'b00) begin   // okay
            bus_errors++;
            $display("error %0t: write response %b, expected 00", $time, axil_rsp.bresp);
         end
         if (axil_rsp.rvalid && axil_req.rready) begin
            reads_checked++;
            if (axil_rsp.rdata !== exp_rdata) begin
               read_errors++;
               $display("error %0t: read data %h, expected %h", $time,
                        axil_rsp.rdata, exp_rdata);
            end
            if (axil_rsp.rresp !== 2'b00) begin
               read_errors++;
               $display("error %0t: read response %b, expected 00", $time, axil_rsp.rresp);
            end
         end
      end
   end

endmodule

// ==== verification/overlay_tb.sv ====
`timescale 1ns/1ps

module overlay_tb import video_stream_pkg::*, ovl_bus_pkg::*; ();

   localparam int clk_period = 40;
   localparam int max_recs   = 128;
   localparam int bus_limit  = 200;   // cycles a bus handshake may take

   logic         clk;
   logic         resetb;
   axil_req_t    axil_req;
   axil_rsp_t    axil_rsp;
   stream_beat_t beat_in;
   stream_beat_t beat_out;
   stream_beat_t exp_beat;
   logic [31:0]  exp_rdata;

   byte          rec_kind [max_recs];
   logic [43:0]  rec_a [max_recs];
   logic [43:0]  rec_b [max_recs];
   int           n_recs = 0;
   bit           loaded = 0;
   byte          bus_kind [$];   // pending bus operations, done in order
   logic [7:0]   bus_addr [$];
   logic [31:0]  bus_data [$];
   bit           bus_busy = 0;
   int           other_errors = 0;
   int           reads_issued = 0;
   int           beats_sent = 0;
   integer       seed = 59;
   int           beat_errors;
   int           read_errors;
   int           bus_errors;
   int           beats_checked;
   int           reads_checked;

   overlay_top #(
      .DIM_WIDTH      (11),
      .OVL_ADDR_WIDTH (10)
   ) UUT (
      .clk      (clk),
      .resetb   (resetb),
      .axil_req (axil_req),
      .axil_rsp (axil_rsp),
      .beat_in  (beat_in),
      .beat_out (beat_out)
   );

   overlay_checker u_checker (
      .clk           (clk),
      .resetb        (resetb),
      .beat_out      (beat_out),
      .exp_beat      (exp_beat),
      .axil_req      (axil_req),
      .axil_rsp      (axil_rsp),
      .exp_rdata     (exp_rdata),
      .beat_errors   (beat_errors),
      .read_errors   (read_errors),
      .bus_errors    (bus_errors),
      .beats_checked (beats_checked),
      .reads_checked (reads_checked)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   task automatic load_stim();
      int          fd;
      string       line;
      byte         kind;
      logic [43:0] a;
      logic [43:0] b;
      fd = $fopen("verification/overlay_stim.txt", "r");
      if (fd == 0) begin
         $display("cannot open verification/overlay_stim.txt");
         other_errors++;
      end else begin
         while ($fgets(line, fd) && n_recs < max_recs) begin
            a = '0;
            b = '0;
            if (line.len() > 1 && line[0] != "#") begin
               void'($sscanf(line, "%c %h %h", kind, a, b));
               rec_kind[n_recs] = kind;
               rec_a[n_recs]    = a;
               rec_b[n_recs]    = b;
               n_recs++;
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic drive_beat(input logic [43:0] beat, input logic [43:0] expected);
      @(negedge clk);
      beat_in  = beat;
      exp_beat = expected;
   endtask

   task automatic drive_gap();
      int           len;
      logic [63:0]  r;
      stream_beat_t idle;
      len = 4 + ($random(seed) & 3);   // frame end needs 4 quiet beats at least
      repeat (len) begin
         r       = {$random(seed), $random(seed)};
         idle    = r[43:0];
         idle.dv = 1'b0;
         drive_beat(idle, idle);
      end
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
      int t;
      @(negedge clk);
      axil_req.awvalid = 1'b1;
      axil_req.awaddr  = addr;
      axil_req.wvalid  = 1'b1;
      axil_req.wdata   = data;
      t = 0;
      do begin
         @(posedge clk);
         t++;
      end while (!axil_rsp.awready && t < bus_limit);
      if (!axil_rsp.awready) begin
         $display("bus write to offset %h was never accepted", addr);
         other_errors++;
      end
      @(negedge clk);
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      t = 0;
      do begin
         @(posedge clk);
         t++;
      end while (!axil_rsp.bvalid && t < bus_limit);
      if (!axil_rsp.bvalid) begin
         $display("bus write to offset %h got no write response", addr);
         other_errors++;
      end
   endtask

   task automatic bus_read(input logic [7:0] addr, input logic [31:0] expected);
      int t;
      @(negedge clk);
      axil_req.arvalid = 1'b1;
      axil_req.araddr  = addr;
      exp_rdata        = expected;
      reads_issued++;
      t = 0;
      do begin
         @(posedge clk);
         t++;
      end while (!axil_rsp.arready && t < bus_limit);
      @(negedge clk);
      axil_req.arvalid = 1'b0;
      t = 0;
      do begin
         @(posedge clk);
         t++;
      end while (!axil_rsp.rvalid && t < bus_limit);   // checker compares on this edge
      if (!axil_rsp.rvalid) begin
         $display("bus read of offset %h returned no data", addr);
         other_errors++;
      end
   endtask

   // bus side runs on its own so writes can overlap live video
   initial begin
      wait (loaded);
      forever begin
         if (bus_kind.size() == 0) begin
            @(negedge clk);
         end else begin
            bus_busy = 1'b1;
            if (bus_kind[0] == "w")
               bus_write(bus_addr[0], bus_data[0]);
            else
               bus_read(bus_addr[0], bus_data[0]);
            void'(bus_kind.pop_front());
            void'(bus_addr.pop_front());
            void'(bus_data.pop_front());
            bus_busy = 1'b0;
         end
      end
   end

   initial begin
      wait (loaded);
      repeat (n_recs * 40 + 100) @(posedge clk);
      $display("watchdog expired before the stimulus finished");
      $display("errors: beat %0d, read %0d, bus %0d, other %0d", beat_errors, read_errors,
               bus_errors, other_errors + 1);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      resetb    = 1'b0;
      axil_req  = '0;
      beat_in   = '0;
      exp_beat  = '0;
      exp_rdata = '0;
      axil_req.bready = 1'b1;
      axil_req.rready = 1'b1;
      load_stim();
      repeat (10) @(posedge clk);
      @(negedge clk);
      resetb = 1'b1;
      loaded = 1'b1;
      for (int i = 0; i < n_recs; i++) begin
         case (rec_kind[i])
            "w", "r": begin
               bus_kind.push_back(rec_kind[i]);
               bus_addr.push_back(rec_a[i][7:0]);
               bus_data.push_back(rec_b[i][31:0]);
            end
            "b": begin
               drive_beat(rec_a[i], rec_b[i]);
               if (rec_b[i][43])
                  beats_sent++;
            end
            "g": drive_gap();
            "s": begin
               while (bus_kind.size() != 0 || bus_busy)
                  drive_beat('0, '0);   // stream idles while the bus finishes
            end
            default: begin
               $display("unknown stimulus record %0d", i);
               other_errors++;
            end
         endcase
      end
      while (bus_kind.size() != 0 || bus_busy)
         drive_beat('0, '0);
      repeat (4) drive_beat('0, '0);
      if (reads_checked != reads_issued) begin
         $display("%0d bus reads issued but %0d checked", reads_issued, reads_checked);
         other_errors++;
      end
      if (beats_checked != beats_sent) begin
         $display("%0d valid beats expected but %0d came out", beats_sent, beats_checked);
         other_errors++;
      end
      $display("errors: beat %0d, read %0d, bus %0d, other %0d", beat_errors, read_errors,
               bus_errors, other_errors);
      if (beat_errors + read_errors + bus_errors + other_errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== verification/overlay_stim.txt ====
# w/r offset data (read data is the expected value), b input beat then expected beat
# beats are 44-bit hex {dv,dtype,y,u,v,meta}, g random idle gap, s wait for bus idle
w 04 00030002
w 08 00020006
w 00 00000000
r 04 00030002
r 08 00020006
r 00 00000000
r 10 00000000
s
b 80000000000 80000000000
b b1020300001 b1020300001
b bfffefd0002 bfffefd0002
b a0000000000 a0000000000
g
w 0C 00000000
w 10 1FE0F010
w 10 00008808
w 04 00000001
w 08 00010004
w 00 00000001
r 00 00000001
r 04 00000001
r 08 00010004
r 0C 00000002
s
b a0000000000 a0000000000
g
b 80000000000 80000000000
b b1020300100 b1020300100
b b1122330101 b8040800101
b b4455660102 b4455660102
b bA060500103 b5C341E0103
b b7788990104 b7788990104
b b1234560105 b1234560105
b 90000000000 90000000000
b b2143650200 b2143650200
b 90000000000 90000000000
b a0000000000 a0000000000
g
b 80000000000 80000000000
b b1020300100 b1020300100
b b1122330101 b8040800101
b b4455660102 b4455660102
w 10 DEADBEEF
w 10 0BADF00D
b bA060500103 b5C341E0103
b b7788990104 b7788990104
b b1234560105 b1234560105
b 90000000000 90000000000
b b2143650200 b2143650200
b 90000000000 90000000000
b a0000000000 a0000000000
g
s
r 0C 00000004
w 0C 00000000
w 10 1FE05830
r 0C 00000001
s
b a0000000000 a0000000000
g
b 80000000000 80000000000
b b1020300100 b1020300100
b b1122330101 b3A453F0101
b b4455660102 b4455660102
b bA060500103 b5C341E0103
b b7788990104 b7788990104
b b1234560105 b1234560105
b 90000000000 90000000000
b b2143650200 b2143650200
b 90000000000 90000000000
b a0000000000 a0000000000
g
s

// ==== files.f ====
rtl/video_stream_pkg.sv
rtl/ovl_bus_pkg.sv
rtl/ovl_regs.sv
rtl/ovl_mem_arbiter.sv
rtl/ovl_fetch.sv
rtl/overlay_blend.sv
rtl/overlay_top.sv
verification/overlay_checker.sv
verification/overlay_tb.sv

// ==== Bender.yml ====
package:
  name: overlay

sources:
  - rtl/video_stream_pkg.sv
  - rtl/ovl_bus_pkg.sv
  - rtl/ovl_regs.sv
  - rtl/ovl_mem_arbiter.sv
  - rtl/ovl_fetch.sv
  - rtl/overlay_blend.sv
  - rtl/overlay_top.sv
  - target: test
    files:
      - verification/overlay_checker.sv
      - verification/overlay_tb.sv
